// File: Bender.yml
package:
  name: eeprom_master

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/i2c_pkg.sv
      - rtl/eeprom_pkg.sv
      - rtl/i2c_bit_engine.sv
      - rtl/eeprom_sequencer.sv
      - rtl/eeprom_apb_regs.sv
      - rtl/eeprom_master_top.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/eeprom_model.sv
      - dv/tb_eeprom_master.sv

// File: dv/eeprom_model.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_model
(
    input  wire  CLK,
    input  wire  RESET,
    input  wire  scl,
    input  wire  sda,
    output logic pull   // high pulls sda low
);

    import eeprom_pkg::*;

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_TX} mode_t;

    localparam int MEM_SIZE = 1 << `EEPROM_ADDR_W;

    logic [`EEPROM_DATA_W-1:0] mem [0:MEM_SIZE-1];
    mode_t                     mode;
    mode_t                     next_mode;
    logic [3:0]                cnt;
    logic [`EEPROM_DATA_W-1:0] shreg;
    logic [`EEPROM_DATA_W-1:0] tx_byte;
    logic [`EEPROM_DATA_W-1:0] wr_byte;
    logic [`EEPROM_ADDR_W-1:0] ptr;
    logic                      wr_pending;
    logic                      refuse;
    logic [7:0]                busy_cnt;
    logic                      scl_q;
    logic                      sda_q;
    logic                      start_seen;
    logic                      stop_seen;
    logic                      rise;
    logic                      fall;
    op_t                       dir;

    assign start_seen = scl && scl_q && sda_q && !sda;
    assign stop_seen  = scl && scl_q && !sda_q && sda;
    assign rise       = scl && !scl_q;
    assign fall       = !scl && scl_q;
    assign dir        = op_t'(shreg[0]);

    initial
    begin
        for (int i = 0; i < MEM_SIZE; i++)
            mem[i] = i[`EEPROM_DATA_W-1:0];  // each byte holds its address
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            mode       <= M_IDLE;
            next_mode  <= M_IDLE;
            cnt        <= '0;
            pull       <= 1'b0;
            wr_pending <= 1'b0;
            refuse     <= 1'b0;
            busy_cnt   <= '0;
        end
        else
        begin
            if (busy_cnt != 0)
                busy_cnt <= busy_cnt - 1'b1;
            if (start_seen)
            begin
                mode   <= M_CTRL;
                cnt    <= '0;
                pull   <= 1'b0;
                refuse <= (busy_cnt != 0);  // internal write cycle still running
            end
            else if (stop_seen)
            begin
                mode       <= M_IDLE;
                pull       <= 1'b0;
                wr_pending <= 1'b0;
                if (wr_pending)
                begin
                    mem[ptr] <= wr_byte;
                    busy_cnt <= 8'd200;
                end
            end
            else if (mode != M_IDLE && rise)
            begin
                shreg <= {shreg[`EEPROM_DATA_W-2:0], sda};
                cnt   <= cnt + 1'b1;
            end
            else if (mode != M_IDLE && fall)
            begin
                if (cnt == 4'd9)
                begin
                    // end of the ack slot
                    cnt       <= '0;
                    mode      <= next_mode;
                    next_mode <= M_IDLE;
                    pull      <= (next_mode == M_TX) ? ~mem[ptr][`EEPROM_DATA_W-1] : 1'b0;
                    tx_byte   <= mem[ptr] << 1;
                end
                else if (mode == M_TX)
                begin
                    if (cnt < 4'd8)
                    begin
                        pull    <= ~tx_byte[`EEPROM_DATA_W-1];
                        tx_byte <= tx_byte << 1;
                    end
                    else
                        pull <= 1'b0;  // master answers here
                end
                else if (cnt == 4'd8)
                begin
                    pull <= 1'b1;
                    case (mode)
                        M_CTRL:
                        begin
                            if (shreg[7:4] != `EEPROM_DEV_CODE || refuse)
                                pull <= 1'b0;
                            else
                            begin
                                ptr[`EEPROM_ADDR_W-1:`EEPROM_DATA_W] <= shreg[3:1];
                                next_mode <= (dir == OP_READ) ? M_TX : M_ADDR;
                            end
                        end
                        M_ADDR:
                        begin
                            ptr[`EEPROM_DATA_W-1:0] <= shreg;
                            next_mode <= M_DATA;
                        end
                        default:
                        begin
                            wr_byte    <= shreg;
                            wr_pending <= 1'b1;  // committed at stop
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_eeprom_master.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module tb_eeprom_master;

    import eeprom_pkg::*;

    localparam int     MEM_SIZE         = 1 << `EEPROM_ADDR_W;
    localparam int     CMD_CYCLES       = 4 * `SCL_QUARTER + 1;
    localparam int     IRQ_LIMIT        = 48 * CMD_CYCLES + 100;
    localparam int     WRITE_CYCLE_WAIT = 260;  // model busy time plus margin
    localparam longint WATCHDOG_NS      = 2 * 20 * 48 * 4 * `SCL_QUARTER * 40;

    logic        CLK;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pslverr;
    wire         irq;
    wire         scl;
    wire         sda_oe;
    wire         sda_line;
    wire         model_pull;
    logic [15:0] lfsr;
    logic [7:0]  ref_mem [0:MEM_SIZE-1];
    int          irq_count;
    logic        scl_d;
    logic        sda_d;
    logic        in_txn;
    wire         start_seen;
    wire         stop_seen;

    assign sda_line = !sda_oe && !model_pull;  // open drain with pull-up

    eeprom_master_top UUT
    (
        .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .sda_in(sda_line), .prdata(prdata),
        .pslverr(pslverr), .irq(irq), .scl(scl), .sda_oe(sda_oe)
    );

    eeprom_model u_eeprom
    (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda_line), .pull(model_pull)
    );

    always #20 CLK = ~CLK;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
            fail_run($sformatf("ERR %s expected 0x%0h actual 0x%0h", name, exp, act));
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic apb_write(input logic [4:0] a, input logic [31:0] d, output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = a;
        pwdata  = d;
        @(negedge CLK);
        penable = 1'b1;
        @(posedge CLK);
        err = pslverr;  // access phase ends at this edge
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] a, output logic [31:0] d, output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = a;
        @(negedge CLK);
        penable = 1'b1;
        @(posedge CLK);
        d   = prdata;
        err = pslverr;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_irq(input string name);
        int n;
        n = 0;
        while (irq !== 1'b1)
        begin
            @(negedge CLK);
            n++;
            if (n > IRQ_LIMIT)
                fail_run($sformatf("no irq within %0d cycles during %s", IRQ_LIMIT, name));
        end
    endtask

    task automatic write_byte(input logic [`EEPROM_ADDR_W-1:0] a, input logic [7:0] d);
        logic        err;
        logic [31:0] v;
        apb_write(REG_ADDR, 32'(a), err);
        check_value("addr write pslverr", 0, err);
        apb_write(REG_WDATA, 32'(d), err);
        check_value("wdata write pslverr", 0, err);
        apb_write(REG_CMD, 32'h1, err);
        check_value("cmd write pslverr", 0, err);
        wait_irq("write");
        apb_read(REG_STATUS, v, err);
        check_value($sformatf("write 0x%0h status", a), 32'h4, v);
        ref_mem[a] = d;
    endtask

    task automatic read_byte(input logic [`EEPROM_ADDR_W-1:0] a, input logic [31:0] cmd);
        logic        err;
        logic [31:0] v;
        apb_write(REG_ADDR, 32'(a), err);
        check_value("addr write pslverr", 0, err);
        apb_write(REG_CMD, cmd, err);
        check_value("cmd write pslverr", 0, err);
        wait_irq("read");
        apb_read(REG_STATUS, v, err);
        check_value($sformatf("read 0x%0h status", a), 32'h4, v);
        apb_read(REG_RDATA, v, err);
        check_value($sformatf("read 0x%0h data", a), 32'(ref_mem[a]), v);
    endtask

    // bus monitor, start and stop bracket every transaction
    assign start_seen = scl && scl_d && sda_d && !sda_line;
    assign stop_seen  = scl && scl_d && !sda_d && sda_line;

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_d     <= 1'b1;
            sda_d     <= 1'b1;
            in_txn    <= 1'b0;
            irq_count <= 0;
        end
        else
        begin
            scl_d <= scl;
            sda_d <= sda_line;
            if (start_seen)
                in_txn <= 1'b1;
            else if (stop_seen)
                in_txn <= 1'b0;
            if (irq)
                irq_count <= irq_count + 1;
        end
    end

    a_scl_in_txn: assert property (@(posedge CLK) disable iff (RESET)
        (scl_d && !scl) |-> in_txn)
        else fail_run("scl toggled outside a start and stop bracket");

    a_stop_in_txn: assert property (@(posedge CLK) disable iff (RESET)
        stop_seen |-> in_txn)
        else fail_run("stop condition without a preceding start");

    a_irq_idle: assert property (@(posedge CLK) disable iff (RESET)
        irq |-> !in_txn && scl && sda_line)
        else fail_run("irq raised while the bus was not idle");

    a_irq_pulse: assert property (@(posedge CLK) disable iff (RESET)
        irq |=> !irq)
        else fail_run("irq longer than one cycle");

    initial
    begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the tests finished");
    end

    initial
    begin
        logic                      err;
        logic [31:0]               v;
        logic [31:0]               d;
        logic [`EEPROM_ADDR_W-1:0] a;
        int                        irq_before;
        CLK     = 1'b0;
        RESET   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr    = 16'd66;
        for (int i = 0; i < MEM_SIZE; i++)
            ref_mem[i] = i[7:0];
        repeat (16) @(negedge CLK);
        RESET = 1'b0;

        @(negedge CLK);
        check_value("reset scl", 1, scl);
        check_value("reset sda", 1, sda_line);
        check_value("reset irq", 0, irq);
        apb_read(REG_STATUS, v, err);
        check_value("reset status", 0, v);
        check_value("reset pslverr", 0, err);

        // untouched location
        take_bits(`EEPROM_ADDR_W, v);
        a = v[`EEPROM_ADDR_W-1:0];
        read_byte(a, 32'h2);

        for (int k = 0; k < 3; k++)
        begin
            take_bits(`EEPROM_ADDR_W, v);
            a = v[`EEPROM_ADDR_W-1:0];
            take_bits(8, d);
            write_byte(a, d[7:0]);
            repeat (WRITE_CYCLE_WAIT) @(negedge CLK);
            read_byte(a, 32'h2);
            read_byte({~a[10:8], a[7:0]}, 32'h2);  // same offset, other block
        end

        // read straight after a write hits the write cycle
        take_bits(`EEPROM_ADDR_W, v);
        a = v[`EEPROM_ADDR_W-1:0];
        take_bits(8, d);
        write_byte(a, d[7:0]);
        apb_write(REG_CMD, 32'h2, err);
        check_value("busy read cmd pslverr", 0, err);
        wait_irq("refused read");
        apb_read(REG_STATUS, v, err);
        check_value("write cycle nack status", 32'h6, v);
        @(negedge CLK);
        check_value("idle scl after nack", 1, scl);
        check_value("idle sda after nack", 1, sda_line);
        repeat (WRITE_CYCLE_WAIT) @(negedge CLK);
        read_byte(a, 32'h2);

        // command refused while busy, both cmd bits set means read
        take_bits(`EEPROM_ADDR_W, v);
        a = v[`EEPROM_ADDR_W-1:0];
        apb_write(REG_ADDR, 32'(a), err);
        check_value("addr write pslverr", 0, err);
        apb_write(REG_CMD, 32'h3, err);
        check_value("first cmd pslverr", 0, err);
        irq_before = irq_count;
        apb_read(REG_STATUS, v, err);
        check_value("status busy bit", 1, v[0]);
        apb_write(REG_CMD, 32'h1, err);
        check_value("cmd while busy pslverr", 1, err);
        wait_irq("read with refused cmd");
        repeat (48 * CMD_CYCLES) @(negedge CLK);  // room for a second transaction
        check_value("irq count", irq_before + 1, irq_count);
        apb_read(REG_STATUS, v, err);
        check_value("status after refused cmd", 32'h4, v);
        apb_read(REG_RDATA, v, err);
        check_value("rdata after refused cmd", 32'(ref_mem[a]), v);

        apb_read(5'h14, v, err);
        check_value("unmapped read pslverr", 1, err);
        apb_write(5'h14, 32'h1, err);
        check_value("unmapped write pslverr", 1, err);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+rtl
rtl/i2c_pkg.sv
rtl/eeprom_pkg.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_apb_regs.sv
rtl/eeprom_master_top.sv
dv/eeprom_model.sv
dv/tb_eeprom_master.sv

// File: rtl/eeprom_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_apb_regs
(
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire [4:0]                  paddr,
    input  wire [31:0]                 pwdata,
    input  wire                        busy,
    input  wire                        done,
    input  wire                        nack,
    input  wire [`EEPROM_DATA_W-1:0]   rdata,
    output logic [31:0]                prdata,
    output logic                       pslverr,
    output logic                       irq,
    output logic                       start,
    output eeprom_pkg::op_t            op,
    output logic [`EEPROM_ADDR_W-1:0]  addr,
    output logic [`EEPROM_DATA_W-1:0]  wdata
);

    import eeprom_pkg::*;

    logic                      access;
    logic                      mapped;
    logic                      busy_any;
    logic                      wr_ok;
    logic                      nack_st;
    logic                      done_st;
    logic [`EEPROM_DATA_W-1:0] rdata_q;

    assign access   = psel && penable;
    assign mapped   = paddr inside {REG_ADDR, REG_WDATA, REG_CMD, REG_STATUS, REG_RDATA};
    assign busy_any = busy || start;  // start is one cycle ahead of busy
    assign pslverr  = access && (!mapped || (pwrite && paddr == REG_CMD && busy_any));
    assign wr_ok    = access && pwrite && !pslverr;

    always_comb
    begin
        prdata = '0;
        case (paddr)
            REG_ADDR:   prdata[`EEPROM_ADDR_W-1:0] = addr;
            REG_WDATA:  prdata[`EEPROM_DATA_W-1:0] = wdata;
            REG_STATUS: prdata[2:0] = {done_st, nack_st, busy};
            REG_RDATA:  prdata[`EEPROM_DATA_W-1:0] = rdata_q;
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            addr    <= '0;
            wdata   <= '0;
            rdata_q <= '0;
            op      <= OP_WRITE;
            start   <= 1'b0;
            irq     <= 1'b0;
            nack_st <= 1'b0;
            done_st <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            irq   <= done;
            // addr and wdata stay put while the sequencer runs
            if (wr_ok && paddr == REG_ADDR && !busy_any)
                addr <= pwdata[`EEPROM_ADDR_W-1:0];
            if (wr_ok && paddr == REG_WDATA && !busy_any)
                wdata <= pwdata[`EEPROM_DATA_W-1:0];
            if (wr_ok && paddr == REG_CMD && (pwdata[1] || pwdata[0]))
            begin
                start <= 1'b1;
                op    <= pwdata[1] ? OP_READ : OP_WRITE;  // read wins
            end
            if (access && !pwrite && paddr == REG_STATUS)
            begin
                nack_st <= 1'b0;  // clear on read
                done_st <= 1'b0;
            end
            if (done)
            begin
                done_st <= 1'b1;
                nack_st <= nack_st || nack;
                if (op == OP_READ && !nack)
                    rdata_q <= rdata;
            end
        end
    end

    a_start_idle: assert property (@(posedge CLK) disable iff (RESET)
        $rose(start) |-> !busy)
        else $error("start raised while sequencer busy");

endmodule

`default_nettype wire

// File: rtl/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// byte address of a 2 KB part, top three bits go out in the control byte
`define EEPROM_ADDR_W 11
`define EEPROM_DATA_W 8

`define EEPROM_DEV_CODE 4'b1010

// system clocks per quarter of an SCL period
`define SCL_QUARTER 5

`endif

// File: rtl/eeprom_master_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_master_top
(
    input  wire          CLK,
    input  wire          RESET,
    input  wire          psel,
    input  wire          penable,
    input  wire          pwrite,
    input  wire [4:0]    paddr,
    input  wire [31:0]   pwdata,
    input  wire          sda_in,
    output logic [31:0]  prdata,
    output logic         pslverr,
    output logic         irq,
    output logic         scl,
    output logic         sda_oe
);

    import eeprom_pkg::*;
    import i2c_pkg::*;

    logic                      start;
    logic                      busy;
    logic                      done;
    logic                      nack;
    op_t                       op;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wdata;
    logic [`EEPROM_DATA_W-1:0] rdata;
    logic                      cmd_valid;
    bit_cmd_t                  cmd;
    logic                      cmd_bit;
    logic                      cmd_done;
    logic                      rx_bit;

    eeprom_apb_regs u_regs
    (
        .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .busy(busy), .done(done), .nack(nack),
        .rdata(rdata), .prdata(prdata), .pslverr(pslverr), .irq(irq), .start(start),
        .op(op), .addr(addr), .wdata(wdata)
    );

    eeprom_sequencer u_seq
    (
        .CLK(CLK), .RESET(RESET), .start(start), .op(op), .addr(addr), .wdata(wdata),
        .cmd_done(cmd_done), .rx_bit(rx_bit), .busy(busy), .done(done), .nack(nack),
        .rdata(rdata), .cmd_valid(cmd_valid), .cmd(cmd), .cmd_bit(cmd_bit)
    );

    i2c_bit_engine u_bit
    (
        .CLK(CLK), .RESET(RESET), .cmd_valid(cmd_valid), .cmd(cmd), .cmd_bit(cmd_bit),
        .sda_in(sda_in), .cmd_done(cmd_done), .rx_bit(rx_bit), .scl(scl), .sda_oe(sda_oe)
    );

endmodule

`default_nettype wire

// File: rtl/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_t;

    typedef enum logic [3:0]
    {
        IDLE, START, CTRL_W, ADDR, DATA_W, RESTART, CTRL_R, DATA_R, STOP, DONE
    } seq_state_t;

    // byte offsets on the apb bus
    localparam logic [4:0] REG_ADDR   = 5'h00;
    localparam logic [4:0] REG_WDATA  = 5'h04;
    localparam logic [4:0] REG_CMD    = 5'h08;
    localparam logic [4:0] REG_STATUS = 5'h0C;
    localparam logic [4:0] REG_RDATA  = 5'h10;

endpackage

`default_nettype wire

// File: rtl/eeprom_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module eeprom_sequencer
(
    input  wire                            CLK,
    input  wire                            RESET,
    input  wire                            start,
    input  wire eeprom_pkg::op_t           op,
    input  wire [`EEPROM_ADDR_W-1:0]       addr,
    input  wire [`EEPROM_DATA_W-1:0]       wdata,
    input  wire                            cmd_done,
    input  wire                            rx_bit,
    output logic                           busy,
    output logic                           done,
    output logic                           nack,
    output logic [`EEPROM_DATA_W-1:0]      rdata,
    output logic                           cmd_valid,
    output i2c_pkg::bit_cmd_t              cmd,
    output logic                           cmd_bit
);

    import eeprom_pkg::*;
    import i2c_pkg::*;

    localparam int BW = $clog2(`EEPROM_DATA_W + 1);

    seq_state_t                 state;
    logic [BW-1:0]              bit_cnt;
    logic [`EEPROM_DATA_W-1:0]  shreg;
    logic                       last_slot;
    logic [2:0]                 blk;

    assign last_slot = (bit_cnt == BW'(`EEPROM_DATA_W));
    assign blk       = addr[`EEPROM_ADDR_W-1:`EEPROM_ADDR_W-3];

    assign busy      = (state != IDLE);
    assign done      = (state == DONE);
    assign cmd_valid = (state != IDLE) && (state != DONE);
    assign rdata     = shreg;

    always_comb
    begin
        cmd     = i2c_pkg::START;  // start and restart
        cmd_bit = 1'b1;
        case (state)
            eeprom_pkg::STOP: cmd = i2c_pkg::STOP;
            CTRL_W, ADDR, DATA_W, CTRL_R:
            begin
                if (last_slot)
                    cmd = READ;  // ack slot
                else
                begin
                    cmd     = WRITE;
                    cmd_bit = shreg[`EEPROM_DATA_W-1];
                end
            end
            DATA_R: cmd = last_slot ? WRITE : READ;  // nack after the byte
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            bit_cnt <= '0;
            nack    <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state <= eeprom_pkg::START;
                        nack  <= 1'b0;
                    end
                end
                DONE: state <= IDLE;
                default:
                begin
                    if (cmd_done)
                    begin
                        case (state)
                            eeprom_pkg::START:
                            begin
                                state   <= CTRL_W;
                                bit_cnt <= '0;
                            end
                            RESTART:
                            begin
                                state   <= CTRL_R;
                                bit_cnt <= '0;
                            end
                            DATA_R:
                            begin
                                if (last_slot)
                                    state <= eeprom_pkg::STOP;
                                else
                                    bit_cnt <= bit_cnt + 1'b1;
                            end
                            eeprom_pkg::STOP: state <= DONE;
                            default:
                            begin
                                if (!last_slot)
                                    bit_cnt <= bit_cnt + 1'b1;
                                else if (rx_bit)
                                begin
                                    nack  <= 1'b1;  // slave did not ack
                                    state <= eeprom_pkg::STOP;
                                end
                                else
                                begin
                                    bit_cnt <= '0;
                                    case (state)
                                        CTRL_W: state <= ADDR;
                                        ADDR:   state <= (op == OP_READ) ? RESTART : DATA_W;
                                        CTRL_R: state <= DATA_R;
                                        default: state <= eeprom_pkg::STOP;
                                    endcase
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // byte shifter, loaded on entry to each byte state
    always_ff @(posedge CLK)
    begin
        if (cmd_done)
        begin
            if (state == eeprom_pkg::START)
                shreg <= {`EEPROM_DEV_CODE, blk, 1'b0};
            else if (state == RESTART)
                shreg <= {`EEPROM_DEV_CODE, blk, 1'b1};
            else if (state == DATA_R && !last_slot)
                shreg <= {shreg[`EEPROM_DATA_W-2:0], rx_bit};
            else if (state inside {CTRL_W, ADDR, DATA_W, CTRL_R} && !last_slot)
                shreg <= {shreg[`EEPROM_DATA_W-2:0], 1'b0};
            else if (state == CTRL_W)
                shreg <= addr[`EEPROM_DATA_W-1:0];
            else if (state == ADDR)
                shreg <= wdata;
        end
    end

    a_cmd_pending: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done |-> cmd_valid)
        else $error("cmd_done without a pending bit command");

    a_rx_known: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done && (cmd == READ) |-> !$isunknown(rx_bit))
        else $error("bit engine returned an unknown bit");

endmodule

`default_nettype wire

// File: rtl/i2c_bit_engine.sv
`timescale 1ns/1ns
`default_nettype none
`include "eeprom_config.svh"

module i2c_bit_engine
(
    input  wire                CLK,
    input  wire                RESET,
    input  wire                cmd_valid,
    input  wire i2c_pkg::bit_cmd_t cmd,
    input  wire                cmd_bit,
    input  wire                sda_in,
    output logic               cmd_done,
    output logic               rx_bit,
    output logic               scl,
    output logic               sda_oe
);

    import i2c_pkg::*;

    localparam int Q  = `SCL_QUARTER;
    localparam int QW = (Q > 1) ? $clog2(Q) : 1;

    logic [QW-1:0] q_cnt;
    logic [1:0]    phase;
    logic          active;
    logic          q_last;
    bit_cmd_t      cur_cmd;
    logic          cur_bit;
    bit_cmd_t      act_cmd;
    logic          act_bit;
    logic          act_en;
    logic [1:0]    act_phase;

    assign q_last   = (q_cnt == QW'(Q - 1));
    assign cmd_done = active && q_last && (phase == 2'd3);

    // line levels are set on entry to each quarter
    assign act_en    = (cmd_valid && !active) || (active && q_last && (phase != 2'd3));
    assign act_phase = active ? phase + 2'd1 : 2'd0;
    assign act_cmd   = active ? cur_cmd : cmd;
    assign act_bit   = active ? cur_bit : cmd_bit;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            phase  <= 2'd0;
            q_cnt  <= '0;
            scl    <= 1'b1;  // idle bus
            sda_oe <= 1'b0;
        end
        else
        begin
            if (cmd_valid && !active)
            begin
                active <= 1'b1;
                phase  <= 2'd0;
                q_cnt  <= '0;
            end
            else if (active)
            begin
                if (q_last)
                begin
                    q_cnt <= '0;
                    phase <= phase + 2'd1;
                    if (phase == 2'd3)
                        active <= 1'b0;
                end
                else
                    q_cnt <= q_cnt + 1'b1;
            end

            if (act_en)
            begin
                case (act_phase)
                    2'd0:
                    begin
                        // scl is low here except before a start
                        if (act_cmd == STOP)
                            sda_oe <= 1'b1;
                        else if (act_cmd == WRITE)
                            sda_oe <= ~act_bit;
                        else
                            sda_oe <= 1'b0;
                    end
                    2'd1: scl <= 1'b1;
                    2'd2:
                    begin
                        if (act_cmd == START)
                            sda_oe <= 1'b1;  // start edge
                        else if (act_cmd == STOP)
                            sda_oe <= 1'b0;  // stop edge
                    end
                    default:
                    begin
                        if (act_cmd != STOP)
                            scl <= 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid && !active)
        begin
            cur_cmd <= cmd;
            cur_bit <= cmd_bit;
        end
        if (active && q_last && (phase == 2'd1) && (cur_cmd == READ))
            rx_bit <= sda_in;  // middle of scl high
    end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $changed(sda_oe)
            |-> active && (phase == 2'd2) && (cur_cmd inside {START, STOP}))
        else $error("sda changed while scl high outside start/stop");

endmodule

`default_nettype wire

// File: rtl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // one bus-level step of the bit engine
    typedef enum logic [1:0]
    {
        START = 2'd0,  // also used for repeated start
        STOP  = 2'd1,
        WRITE = 2'd2,
        READ  = 2'd3
    } bit_cmd_t;

endpackage

`default_nettype wire
